//--- cpu_pads.f
hw/pad_bus_pkg.sv
hw/bus_slice.sv
hw/acc_cpu.sv
hw/pad_frame_seq.sv
hw/cpu_pad_top.sv
bench/pad_memory_model.sv
bench/tb_cpu_pad_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_cpu_pad_top -f cpu_pads.f \
  && ./obj_dir/Vtb_cpu_pad_top | tee /dev/stderr | grep -F "TEST OK" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- bench/tb_cpu_pad_top.sv
/*
 * Testbench for cpu_pad_top, directed programs run against the pad
 * memory model, with a compare task and a cycle timeout
 */
`timescale 1ns/1ps

module tb_cpu_pad_top
  import pad_bus_pkg::*;
();

  localparam int RUN_LIMIT      = 2000;     // About 60 transactions of up to 12 cycles plus margin
  localparam int QUIET_CYCLES   = 50;
  localparam logic [15:0] DATA_A = 16'h0100;  // Data words sit above the program
  localparam logic [15:0] DATA_B = 16'h0104;
  localparam logic [15:0] DATA_C = 16'h0108;

  logic             clk, reset, clear, load_en;
  logic [7:0]       load_idx;
  logic [31:0]      load_data;
  logic [PAD_W-1:0] pad_addr, pad_wdata, pad_rdata;
  logic             pad_oe, pad_frame, pad_write, halted;
  logic [31:0]      wr_count, last_wr_addr, last_wr_data;
  logic [31:0]      rng_state;
  int               frame_count;
  int               write_frames;
  int               oe_cycles;
  int               oe_stray;

  cpu_pad_top DUT (
    .clk(clk), .reset(reset), .pad_addr(pad_addr), .pad_wdata(pad_wdata),
    .pad_oe(pad_oe), .pad_frame(pad_frame), .pad_write(pad_write),
    .pad_rdata(pad_rdata), .halted(halted)
  );

  pad_memory_model u_mem (
    .clk(clk), .clear(clear), .load_en(load_en), .load_idx(load_idx),
    .load_data(load_data), .pad_addr(pad_addr), .pad_wdata(pad_wdata),
    .pad_frame(pad_frame), .pad_write(pad_write), .pad_rdata(pad_rdata),
    .wr_count(wr_count), .last_wr_addr(last_wr_addr), .last_wr_data(last_wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin         // Pad activity sampled mid-cycle
    frame_count  += int'(pad_frame);
    write_frames += int'(pad_frame && pad_write);
    oe_cycles    += int'(pad_oe);
    oe_stray     += int'(pad_oe && !pad_write);
  end

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  task automatic draw_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  function automatic logic [31:0] encode(input logic [3:0] op, input logic [15:0] operand);
    return {op, 12'h000, operand};
  endfunction

  task automatic hold_reset();         // Core held in reset while memory is emptied
    reset = 1'b1;
    clear = 1'b1;
    step_cycle();
    clear = 1'b0;
  endtask

  task automatic load_word(input logic [15:0] byte_addr, input logic [31:0] word);
    load_en   = 1'b1;
    load_idx  = byte_addr[9:2];
    load_data = word;
    step_cycle();
    load_en   = 1'b0;
  endtask

  task automatic release_reset();
    repeat (5) step_cycle();
    reset = 1'b0;
  endtask

  task automatic run_until_halted();
    int cycles;
    cycles = 0;
    while (!halted) begin
      step_cycle();
      cycles++;
      if (cycles > RUN_LIMIT) begin
        $display("Timeout: the CPU did not halt within %0d cycles", RUN_LIMIT);
        stop_on_error();
      end
    end
  endtask

  task automatic test_reset_and_first_frame();
    logic [31:0] addr;
    int          cycles;
    hold_reset();
    release_reset();
    check_value("pad_frame", 32'(pad_frame), 32'h0);
    check_value("pad_oe", 32'(pad_oe), 32'h0);
    check_value("pad_write", 32'(pad_write), 32'h0);
    check_value("halted", 32'(halted), 32'h0);
    check_value("pad_addr", 32'(pad_addr), 32'h0);
    check_value("pad_wdata", 32'(pad_wdata), 32'h0);
    cycles = 0;
    while (!pad_frame) begin
      step_cycle();
      cycles++;
      if (cycles > RUN_LIMIT) begin
        $display("Timeout: no pad frame started after reset");
        stop_on_error();
      end
    end
    for (int i = 0; i < WORD_BYTES; i++) begin
      addr[i*PAD_W +: PAD_W] = pad_addr;   // Least significant byte first
      check_value("pad_write", 32'(pad_write), 32'h0);
      step_cycle();
    end
    check_value("first frame address", addr, RESET_PC);
    run_until_halted();
  endtask

  task automatic test_store_immediate();
    logic [31:0] r;
    int          oe_before, wf_before, stray_before;
    draw_random(r);
    hold_reset();
    load_word(16'h0000, encode(OP_LDI, r[15:0]));
    load_word(16'h0004, encode(OP_STORE, DATA_C));
    load_word(16'h0008, encode(OP_HALT, 16'h0000));
    release_reset();
    oe_before    = oe_cycles;
    wf_before    = write_frames;
    stray_before = oe_stray;
    run_until_halted();
    check_value("wr_count", wr_count, 32'd1);
    check_value("last_wr_addr", last_wr_addr, {16'h0, DATA_C});
    check_value("last_wr_data", last_wr_data, {16'h0, r[15:0]});
    check_value("pad_oe cycles", 32'(oe_cycles - oe_before), 32'(WORD_BYTES));
    check_value("write frames", 32'(write_frames - wf_before), 32'd1);
    check_value("pad_oe outside write", 32'(oe_stray - stray_before), 32'd0);
  endtask

  task automatic test_load_add_store();
    logic [31:0] a, b;
    draw_random(a);
    draw_random(b);
    hold_reset();
    load_word(16'h0000, encode(OP_LOAD, DATA_A));
    load_word(16'h0004, encode(OP_ADD, DATA_B));
    load_word(16'h0008, encode(OP_STORE, DATA_C));
    load_word(16'h000c, encode(OP_HALT, 16'h0000));
    load_word(DATA_A, a);
    load_word(DATA_B, b);
    release_reset();
    run_until_halted();
    check_value("wr_count", wr_count, 32'd1);
    check_value("last_wr_addr", last_wr_addr, {16'h0, DATA_C});
    check_value("last_wr_data", last_wr_data, a + b);  // Wraps at 32 bits
  endtask

  task automatic test_countdown_loop();
    logic [31:0] r;
    int          n;
    draw_random(r);
    n = int'(r[2:0]) + 1;
    hold_reset();
    load_word(16'h0000, encode(OP_LOAD, DATA_A));  // Loop head reloads the counter
    load_word(16'h0004, encode(OP_ADD, DATA_B));
    load_word(16'h0008, encode(OP_STORE, DATA_A));
    load_word(16'h000c, encode(OP_JNZ, 16'h0000));
    load_word(16'h0010, encode(OP_HALT, 16'h0000));
    load_word(DATA_A, 32'(n));
    load_word(DATA_B, 32'hffff_ffff);
    release_reset();
    run_until_halted();
    check_value("wr_count", wr_count, 32'(n));
    check_value("last_wr_addr", last_wr_addr, {16'h0, DATA_A});
    check_value("last_wr_data", last_wr_data, 32'h0);
  endtask

  task automatic test_halt_quiet(input logic [3:0] op);
    int frames_before;
    hold_reset();
    load_word(16'h0000, encode(OP_LDI, 16'h0055));
    load_word(16'h0004, encode(op, 16'h0000));
    load_word(16'h0008, encode(OP_STORE, DATA_A));   // Never reached
    release_reset();
    run_until_halted();
    frames_before = frame_count;
    repeat (QUIET_CYCLES) step_cycle();
    check_value("frames after halt", 32'(frame_count - frames_before), 32'd0);
    check_value("halted", 32'(halted), 32'h1);
    check_value("wr_count", wr_count, 32'd0);
  endtask

  initial begin
    reset     = 1'b1;
    clear     = 1'b1;
    load_en   = 1'b0;
    load_idx  = '0;
    load_data = '0;
    rng_state = 32'h63cc;
    test_reset_and_first_frame();
    test_store_immediate();
    test_load_add_store();
    test_countdown_loop();
    test_halt_quiet(OP_HALT);
    test_halt_quiet(4'hf);                 // Unknown opcode
    $display("TEST OK");
    $finish;
  end

endmodule

//--- bench/pad_memory_model.sv
/*
 * Behavioral external memory on the byte-serial pad frame,
 * 256 words, load port and write statistics
 */
`timescale 1ns/1ps

module pad_memory_model (
  input  logic        clk,
  input  logic        clear,          // Empties memory and statistics
  input  logic        load_en,
  input  logic [7:0]  load_idx,
  input  logic [31:0] load_data,
  input  logic [7:0]  pad_addr,
  input  logic [7:0]  pad_wdata,
  input  logic        pad_frame,
  input  logic        pad_write,
  output logic [7:0]  pad_rdata,
  output logic [31:0] wr_count,
  output logic [31:0] last_wr_addr,
  output logic [31:0] last_wr_data
);

  logic [31:0] mem [256];
  logic [31:0] addr_b, data_b, rd_word;
  logic [7:0]  next_rdata;
  logic        is_wr;
  int          step;                  // Last frame phase seen, 0 when idle

  initial begin
    pad_rdata    = '0;
    next_rdata   = '0;
    wr_count     = '0;
    last_wr_addr = '0;
    last_wr_data = '0;
    step         = 0;
    forever begin
      @(posedge clk);
      if (clear) begin
        foreach (mem[i]) begin
          mem[i] = '0;                 // Zero decodes as HALT
        end
        step         = 0;
        next_rdata   = '0;
        wr_count     = '0;
        last_wr_addr = '0;
        last_wr_data = '0;
      end else begin
        if (load_en) begin
          mem[load_idx] = load_data;
        end
        if (pad_frame) begin
          addr_b = {24'h0, pad_addr};  // Byte 0 arrives with the strobe
          data_b = {24'h0, pad_wdata};
          is_wr  = pad_write;
          step   = 1;
        end else if (step >= 1 && step <= 3) begin
          addr_b[step*8 +: 8] = pad_addr;
          data_b[step*8 +: 8] = pad_wdata;
          step++;
          if (step == 4 && is_wr) begin
            mem[addr_b[9:2]] = data_b;
            wr_count++;
            last_wr_addr = addr_b;
            last_wr_data = data_b;
            step         = 0;
          end else if (step == 4) begin
            rd_word    = mem[addr_b[9:2]];
            next_rdata = rd_word[7:0];  // Shown in phase 5
            step       = 5;
          end
        end else if (step >= 5 && step <= 7) begin
          rd_word    = mem[addr_b[9:2]];
          next_rdata = rd_word[(step-4)*8 +: 8];
          step++;
        end else if (step == 8) begin
          next_rdata = '0;
          step       = 0;
        end
      end
      #1;
      pad_rdata = next_rdata;
    end
  end

endmodule

//--- hw/cpu_pad_top.sv
/*
 * Chip top, accumulator core and pad sequencer joined through
 * a register slice on each bus channel
 */
`timescale 1ns/1ps

module cpu_pad_top
  import pad_bus_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  output logic [PAD_W-1:0] pad_addr,
  output logic [PAD_W-1:0] pad_wdata,
  output logic             pad_oe,
  output logic             pad_frame,
  output logic             pad_write,
  input  logic [PAD_W-1:0] pad_rdata,
  output logic             halted
);

  // Core side
  logic     core_req_valid;
  logic     core_req_ready;
  bus_req_t core_req;
  logic     core_rsp_valid;
  logic     core_rsp_ready;
  bus_rsp_t core_rsp;

  // Sequencer side
  logic     seq_req_valid;
  logic     seq_req_ready;
  bus_req_t seq_req;
  logic     seq_rsp_valid;
  logic     seq_rsp_ready;
  bus_rsp_t seq_rsp;

  acc_cpu u_cpu (
    .clk       (clk),
    .reset     (reset),
    .req_valid (core_req_valid),
    .req_ready (core_req_ready),
    .req       (core_req),
    .rsp_valid (core_rsp_valid),
    .rsp_ready (core_rsp_ready),
    .rsp       (core_rsp),
    .halted    (halted)
  );

  bus_slice #(.payload_t(bus_req_t)) u_req_slice (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (core_req_valid),
    .in_ready  (core_req_ready),
    .in_data   (core_req),
    .out_valid (seq_req_valid),
    .out_ready (seq_req_ready),
    .out_data  (seq_req)
  );

  bus_slice #(.payload_t(bus_rsp_t)) u_rsp_slice (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (seq_rsp_valid),
    .in_ready  (seq_rsp_ready),
    .in_data   (seq_rsp),
    .out_valid (core_rsp_valid),
    .out_ready (core_rsp_ready),
    .out_data  (core_rsp)
  );

  pad_frame_seq u_seq (
    .clk       (clk),
    .reset     (reset),
    .req_valid (seq_req_valid),
    .req_ready (seq_req_ready),
    .req       (seq_req),
    .rsp_valid (seq_rsp_valid),
    .rsp_ready (seq_rsp_ready),
    .rsp       (seq_rsp),
    .pad_addr  (pad_addr),
    .pad_wdata (pad_wdata),
    .pad_oe    (pad_oe),
    .pad_frame (pad_frame),
    .pad_write (pad_write),
    .pad_rdata (pad_rdata)
  );

endmodule

//--- hw/pad_frame_seq.sv
/*
 * Byte-serial pad sequencer, turns one bus request into a phased
 * pad frame and assembles the read word from the pad bytes
 */
`timescale 1ns/1ps

module pad_frame_seq
  import pad_bus_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  // Request channel
  input  logic             req_valid,
  output logic             req_ready,
  input  bus_req_t         req,
  // Response channel
  output logic             rsp_valid,
  input  logic             rsp_ready,
  output bus_rsp_t         rsp,
  // Pads
  output logic [PAD_W-1:0] pad_addr,
  output logic [PAD_W-1:0] pad_wdata,
  output logic             pad_oe,
  output logic             pad_frame,
  output logic             pad_write,
  input  logic [PAD_W-1:0] pad_rdata
);

  logic [PHASE_W-1:0]    phase;
  logic [PHASE_W-1:0]    phase_d;
  bus_req_t              req_q;       // Request of the active frame
  bus_req_t              cur;         // Request seen by the pad muxes
  logic [DATA_W-1:0]     rdata_q;
  logic [BYTE_SEL_W-1:0] addr_sel;
  logic [BYTE_SEL_W-1:0] rd_sel;
  logic                  accept;
  logic                  addr_phase;  // Next phase drives address bytes
  logic                  in_frame;
  logic                  rd_phase;

  assign req_ready = (phase == PH_IDLE);
  assign accept    = req_valid && req_ready;
  assign rsp_valid = (phase == PH_RSP);
  assign rsp       = '{rdata: rdata_q};

  // Next phase
  always_comb begin
    phase_d = phase + 1'b1;
    case (phase)
      PH_IDLE:      phase_d = req_valid ? PH_FIRST : PH_IDLE;
      PH_ADDR_LAST: phase_d = req_q.write ? PH_RSP : PH_READ_FIRST;
      PH_READ_LAST: phase_d = PH_RSP;
      PH_RSP:       phase_d = rsp_ready ? PH_IDLE : PH_RSP;  // Hold until taken
      default:      phase_d = phase + 1'b1;
    endcase
  end

  // Pads are registered, so they follow the next phase
  assign cur        = (phase == PH_IDLE) ? req : req_q;
  assign addr_phase = (phase_d >= PH_FIRST) && (phase_d <= PH_ADDR_LAST);
  assign in_frame   = (phase_d >= PH_FIRST) && (phase_d <= PH_READ_LAST);
  assign addr_sel   = BYTE_SEL_W'(phase_d - PH_FIRST);
  assign rd_phase   = (phase >= PH_READ_FIRST) && (phase <= PH_READ_LAST);
  assign rd_sel     = BYTE_SEL_W'(phase - PH_READ_FIRST);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase     <= PH_IDLE;
      pad_addr  <= '0;
      pad_wdata <= '0;
      pad_oe    <= 1'b0;
      pad_frame <= 1'b0;
      pad_write <= 1'b0;
    end else begin
      phase     <= phase_d;
      pad_frame <= accept;                 // Phase 1 is entered only from idle
      pad_write <= in_frame && cur.write;
      pad_oe    <= addr_phase && cur.write;
      if (addr_phase) begin
        pad_addr  <= cur.addr[addr_sel*PAD_W +: PAD_W];    // LSB first
        pad_wdata <= cur.wdata[addr_sel*PAD_W +: PAD_W];
      end else begin
        pad_addr  <= '0;
        pad_wdata <= '0;
      end
    end
  end

  // Request latch and read word assembly
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q   <= req;
      rdata_q <= '0;                       // Write acks return zero
    end else if (rd_phase) begin
      rdata_q[rd_sel*PAD_W +: PAD_W] <= pad_rdata;
    end
  end

  // Frame strobe lines up with the registered phase
  a_frame_phase : assert property (
    @(posedge clk) disable iff (reset)
    pad_frame |-> (phase == PH_FIRST)
  ) else $error("pad_frame_seq: frame strobe outside phase 1");

endmodule

//--- hw/acc_cpu.sv
/*
 * Accumulator core, fetches and executes one instruction at a time
 * over the request/response bus channels
 */
`timescale 1ns/1ps

module acc_cpu
  import pad_bus_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // Request channel
  output logic     req_valid,
  input  logic     req_ready,
  output bus_req_t req,
  // Response channel
  input  logic     rsp_valid,
  output logic     rsp_ready,
  input  bus_rsp_t rsp,
  output logic     halted
);

  typedef enum logic [2:0] {
    S_FETCH,
    S_WAIT_FETCH,
    S_EXEC,
    S_WAIT_DATA,
    S_HALT
  } state_t;

  state_t            state;
  logic [ADDR_W-1:0] pc;
  logic [DATA_W-1:0] acc;
  logic [DATA_W-1:0] ir;           // Current instruction word
  logic [3:0]        opcode;
  logic [ADDR_W-1:0] operand_addr;
  logic              req_fire;
  logic              rsp_fire;

  assign opcode       = ir[31:28];
  assign operand_addr = {{(ADDR_W-16){1'b0}}, ir[15:0]};  // Byte address
  assign req_fire     = req_valid && req_ready;
  assign rsp_fire     = rsp_valid && rsp_ready;

  // Only the wait states take a response
  assign rsp_ready = (state == S_WAIT_FETCH) || (state == S_WAIT_DATA);
  assign halted    = (state == S_HALT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_FETCH;
      pc        <= RESET_PC;
      acc       <= '0;
      req_valid <= 1'b0;
    end else begin
      if (req_fire) begin
        req_valid <= 1'b0;                 // Request taken by the slice
      end
      case (state)
        S_FETCH: begin
          req_valid <= 1'b1;
          state     <= S_WAIT_FETCH;
        end
        S_WAIT_FETCH: begin
          if (rsp_fire) begin
            pc    <= pc + ADDR_W'(WORD_BYTES);
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          case (opcode)
            OP_LDI: begin
              acc   <= {{(DATA_W-16){1'b0}}, ir[15:0]};
              state <= S_FETCH;
            end
            OP_LOAD, OP_ADD, OP_STORE: begin
              req_valid <= 1'b1;           // Data access, payload set below
              state     <= S_WAIT_DATA;
            end
            OP_JNZ: begin
              if (acc != '0) begin
                pc <= operand_addr;
              end
              state <= S_FETCH;
            end
            default: begin
              state <= S_HALT;             // HALT and unknown opcodes
            end
          endcase
        end
        S_WAIT_DATA: begin
          if (rsp_fire) begin
            if (opcode == OP_LOAD) begin
              acc <= rsp.rdata;
            end else if (opcode == OP_ADD) begin
              acc <= acc + rsp.rdata;      // Wraps at 32 bits
            end
            state <= S_FETCH;              // Store ack carries nothing
          end
        end
        S_HALT: begin
          state <= S_HALT;
        end
        default: begin
          state <= S_HALT;
        end
      endcase
    end
  end

  // Request payload and instruction register
  always_ff @(posedge clk) begin
    if (state == S_FETCH) begin
      req <= '{addr: pc, wdata: '0, write: 1'b0};
    end else if (state == S_EXEC) begin
      req <= '{addr: operand_addr, wdata: acc, write: (opcode == OP_STORE)};
    end
    if (state == S_WAIT_FETCH && rsp_fire) begin
      ir <= rsp.rdata;
    end
  end

  // Once halted the core stays off the bus
  a_no_req_halted : assert property (
    @(posedge clk) disable iff (reset)
    halted |-> !req_valid
  ) else $error("acc_cpu: request raised while halted");

endmodule

//--- hw/bus_slice.sv
/*
 * One-entry register slice with valid/ready on both sides,
 * payload type given as a type parameter
 */
`timescale 1ns/1ps

module bus_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  // Upstream side
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  // Downstream side
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;

  // Empty, or the held entry leaves this cycle
  assign in_ready = !full || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full;
  assign out_data  = data_q;

  // A stalled entry must not change under the consumer
  a_hold_stable : assert property (
    @(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else $error("bus_slice: payload changed while stalled");

endmodule

//--- hw/pad_bus_pkg.sv
/*
 * Shared bus widths, request and response payload structs,
 * accumulator opcodes and pad frame phase constants
 */
package pad_bus_pkg;

  // Bus and pad widths
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int PAD_W      = 8;
  localparam int WORD_BYTES = 4;
  localparam int BYTE_SEL_W = $clog2(WORD_BYTES);

  localparam logic [ADDR_W-1:0] RESET_PC = '0;      // First fetch address

  // Reduced AXI4-Lite request, one channel for reads and writes
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              write;
  } bus_req_t;

  // Read data, or zero as the write acknowledge
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Opcodes in instruction bits 31..28
  localparam logic [3:0] OP_HALT  = 4'h0;
  localparam logic [3:0] OP_LDI   = 4'h1;
  localparam logic [3:0] OP_LOAD  = 4'h2;
  localparam logic [3:0] OP_ADD   = 4'h3;
  localparam logic [3:0] OP_STORE = 4'h4;
  localparam logic [3:0] OP_JNZ   = 4'h5;

  // Pad frame phases
  localparam int PHASE_W = 4;
  localparam logic [PHASE_W-1:0] PH_IDLE       = 4'd0;
  localparam logic [PHASE_W-1:0] PH_FIRST      = 4'd1;   // Address byte 0, frame strobe
  localparam logic [PHASE_W-1:0] PH_ADDR_LAST  = 4'd4;
  localparam logic [PHASE_W-1:0] PH_READ_FIRST = 4'd5;
  localparam logic [PHASE_W-1:0] PH_READ_LAST  = 4'd8;
  localparam logic [PHASE_W-1:0] PH_RSP        = 4'd9;   // Response held here

endpackage
